// File: compile.f
hdl/ppc_types.sv
hdl/wb_config.sv
hdl/int_exec_unit.sv
hdl/gpr_write_back_arbiter.sv
hdl/gpr_commit.sv
hdl/ppc_wb_top.sv
sim/ppc_wb_props.sv
sim/ppc_wb_tb.sv

// File: hdl/gpr_commit.sv
// ##########################################################################
// GPR, CR0 and XER commit stage
// ##########################################################################

`timescale 1ns/1ps

module gpr_commit (
    input  logic clk,
    input  logic rst,
    input  logic wb_valid,
    output logic wb_ready,
    input  logic [0:wb_config::RS_ID_WIDTH-1] wb_rs_id,
    input  logic [0:wb_config::GPR_ADDR_WIDTH-1] wb_addr,
    input  logic [0:wb_config::DATA_WIDTH-1] wb_result,
    input  ppc_types::cond_exception_t wb_cond,
    output logic completion_valid,
    input  logic completion_ready,
    output logic [0:wb_config::RS_ID_WIDTH-1] completion_rs_id,
    input  logic [0:wb_config::GPR_ADDR_WIDTH-1] read_addr,
    output logic [0:wb_config::DATA_WIDTH-1] read_data,
    output logic [0:3] cr0,
    output logic [0:2] xer
);
    import ppc_types::*;
    import wb_config::*;

    logic [0:DATA_WIDTH-1] gpr [0:NUM_GPRS-1];
    logic [0:2] xer_next;
    logic [0:3] cr0_next;
    logic wb_fire;

    // Accept when the completion slot is empty or being taken
    assign wb_ready = !completion_valid || completion_ready;
    assign wb_fire = wb_valid && wb_ready;

    // Operand read port
    assign read_data = gpr[read_addr];

    always_comb begin
        xer_next = xer;
        if (wb_cond.ov_en) begin
            xer_next[XER_OV] = wb_cond.ov;
            // SO is sticky
            if (wb_cond.ov) begin
                xer_next[XER_SO] = 1'b1;
            end
        end
        if (wb_cond.ca_en) begin
            xer_next[XER_CA] = wb_cond.ca;
        end
        cr0_next = cr0;
        // Record form, SO copied from the updated XER
        if (wb_cond.cr0_en) begin
            cr0_next[CR_LT] = wb_cond.cr0_lt;
            cr0_next[CR_GT] = wb_cond.cr0_gt;
            cr0_next[CR_EQ] = wb_cond.cr0_eq;
            cr0_next[CR_SO] = xer_next[XER_SO];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_GPRS; i++) begin
                gpr[i] <= '0;
            end
            cr0 <= '0;
            xer <= '0;
            completion_valid <= 1'b0;
        end else if (wb_fire) begin
            // Architectural state updates on the accepting edge
            gpr[wb_addr] <= wb_result;
            cr0 <= cr0_next;
            xer <= xer_next;
            completion_valid <= 1'b1;
        end else if (completion_ready) begin
            completion_valid <= 1'b0;
        end
    end

    // Completion tag
    always_ff @(posedge clk) begin
        if (wb_fire) begin
            completion_rs_id <= wb_rs_id;
        end
    end

endmodule

// File: hdl/gpr_write_back_arbiter.sv
// ##########################################################################
// Round-robin write-back arbiter
// ##########################################################################

`timescale 1ns/1ps

module gpr_write_back_arbiter #(
    parameter int ARBITER_DEPTH = wb_config::NUM_UNITS
) (
    input  logic clk,
    input  logic rst,
    input  logic input_valid [0:ARBITER_DEPTH-1],
    output logic input_ready [0:ARBITER_DEPTH-1],
    input  logic [0:wb_config::RS_ID_WIDTH-1] rs_id_in [0:ARBITER_DEPTH-1],
    input  logic [0:wb_config::GPR_ADDR_WIDTH-1] result_reg_addr_in [0:ARBITER_DEPTH-1],
    input  logic [0:wb_config::DATA_WIDTH-1] result_in [0:ARBITER_DEPTH-1],
    input  ppc_types::cond_exception_t cr0_xer_in [0:ARBITER_DEPTH-1],
    output logic output_valid,
    input  logic output_ready,
    output logic [0:wb_config::RS_ID_WIDTH-1] rs_id_out,
    output logic [0:wb_config::GPR_ADDR_WIDTH-1] result_reg_addr_out,
    output logic [0:wb_config::DATA_WIDTH-1] result_out,
    output ppc_types::cond_exception_t cr0_xer_out
);

    logic [0:$clog2(ARBITER_DEPTH)-1] pointer_ff;
    logic [0:$clog2(ARBITER_DEPTH)-1] grant_idx;
    logic [0:$clog2(ARBITER_DEPTH)-1] held_idx_ff;
    logic [0:$clog2(ARBITER_DEPTH)-1] next_ptr;
    logic grant_found;
    logic hold_ff;
    logic out_fire;

    // First valid input at or after the pointer
    always_comb begin : grant_search
        logic [0:$clog2(ARBITER_DEPTH)-1] cand;
        grant_found = 1'b0;
        grant_idx = pointer_ff;
        cand = pointer_ff;
        for (int i = 0; i < ARBITER_DEPTH; i++) begin
            if (!grant_found && input_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx = cand;
            end
            cand = (cand == ARBITER_DEPTH - 1) ? '0 : cand + 1'b1;
        end
        // A stalled grant is kept, a late valid cannot steal the bus
        if (hold_ff) begin
            grant_found = input_valid[held_idx_ff];
            grant_idx = held_idx_ff;
        end
    end

    // Ready goes back to the granted input only
    always_comb begin
        for (int i = 0; i < ARBITER_DEPTH; i++) begin
            input_ready[i] = output_ready && grant_found && (grant_idx == i);
        end
    end

    assign output_valid = grant_found;
    assign rs_id_out = rs_id_in[grant_idx];
    assign result_reg_addr_out = result_reg_addr_in[grant_idx];
    assign result_out = result_in[grant_idx];
    assign cr0_xer_out = cr0_xer_in[grant_idx];

    assign out_fire = output_valid && output_ready;
    assign next_ptr = (grant_idx == ARBITER_DEPTH - 1) ? '0 : grant_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            pointer_ff <= '0;
            hold_ff <= 1'b0;
        end else begin
            // Pointer moves only on a real transfer
            if (out_fire) begin
                pointer_ff <= next_ptr;
            end
            hold_ff <= output_valid && !output_ready;
        end
    end

    always_ff @(posedge clk) begin
        held_idx_ff <= grant_idx;
    end

endmodule

// File: hdl/int_exec_unit.sv
// ##########################################################################
// Integer execution unit
// ##########################################################################

`timescale 1ns/1ps

module int_exec_unit (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    output logic issue_ready,
    input  ppc_types::exec_op_t op,
    input  logic [0:wb_config::DATA_WIDTH-1] operand_a,
    input  logic [0:wb_config::DATA_WIDTH-1] operand_b,
    input  logic rc,
    input  logic oe,
    input  logic [0:wb_config::RS_ID_WIDTH-1] rs_id_in,
    input  logic [0:wb_config::GPR_ADDR_WIDTH-1] dest_addr_in,
    output logic result_valid,
    input  logic result_ready,
    output logic [0:wb_config::RS_ID_WIDTH-1] rs_id_out,
    output logic [0:wb_config::GPR_ADDR_WIDTH-1] dest_addr_out,
    output logic [0:wb_config::DATA_WIDTH-1] result_out,
    output ppc_types::cond_exception_t cond_out
);
    import ppc_types::*;
    import wb_config::*;

    // Adder operands, bit 0 catches the carry out
    logic [0:DATA_WIDTH] add_lhs;
    logic [0:DATA_WIDTH] add_rhs;
    logic [0:DATA_WIDTH] add_sum;
    logic add_cin;
    logic [0:DATA_WIDTH-1] alu_result;
    cond_exception_t alu_cond;
    logic issue_fire;

    // Slot free, or draining this cycle
    assign issue_ready = !result_valid || result_ready;
    assign issue_fire = issue_valid && issue_ready;

    // subf is b + ~a + 1
    always_comb begin
        if (op == op_subf) begin
            add_lhs = {1'b0, ~operand_a};
            add_cin = 1'b1;
        end else begin
            add_lhs = {1'b0, operand_a};
            add_cin = 1'b0;
        end
    end

    assign add_rhs = {1'b0, operand_b};
    assign add_sum = add_lhs + add_rhs + {{DATA_WIDTH{1'b0}}, add_cin};

    always_comb begin
        alu_cond = '0;
        case (op)
            op_and:  alu_result = operand_a & operand_b;
            op_or:   alu_result = operand_a | operand_b;
            op_xor:  alu_result = operand_a ^ operand_b;
            default: alu_result = add_sum[1:DATA_WIDTH];
        endcase
        // Arithmetic forms only
        if (op == op_add || op == op_addc || op == op_subf) begin
            // Same input signs but the sum flips sign
            alu_cond.ov = (add_lhs[1] == add_rhs[1]) && (alu_result[0] != add_lhs[1]);
            alu_cond.ca = add_sum[0];
        end
        // Signed compare against zero
        alu_cond.cr0_lt = alu_result[0];
        alu_cond.cr0_eq = (alu_result == '0);
        alu_cond.cr0_gt = !alu_result[0] && (alu_result != '0);
        alu_cond.cr0_en = rc;
        alu_cond.ov_en = oe;
        alu_cond.ca_en = (op == op_addc) || (op == op_subf);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (issue_fire) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    // Result slot payload
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            rs_id_out <= rs_id_in;
            dest_addr_out <= dest_addr_in;
            result_out <= alu_result;
            cond_out <= alu_cond;
        end
    end

endmodule

// File: hdl/ppc_types.sv
// ##########################################################################
// PowerPC integer types
// ##########################################################################

package ppc_types;

    // Operations the integer units execute
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_addc = 3'd1,
        op_subf = 3'd2,
        op_and  = 3'd3,
        op_or   = 3'd4,
        op_xor  = 3'd5
    } exec_op_t;

    // CR0 field bit positions, big-endian numbering
    localparam int CR_LT = 0;
    localparam int CR_GT = 1;
    localparam int CR_EQ = 2;
    localparam int CR_SO = 3;

    // XER bits kept by the core
    localparam int XER_SO = 0;
    localparam int XER_OV = 1;
    localparam int XER_CA = 2;

    // Status that travels with each result
    typedef struct packed {
        logic cr0_lt;
        logic cr0_gt;
        logic cr0_eq;
        logic ov;
        logic ca;
        logic cr0_en;
        logic ov_en;
        logic ca_en;
    } cond_exception_t;

endpackage

// File: hdl/ppc_wb_top.sv
// ##########################################################################
// Write-back path top level
// ##########################################################################

`timescale 1ns/1ps

module ppc_wb_top (
    input  logic clk,
    input  logic rst,
    // Unit 0 issue
    input  logic issue_valid_u0,
    output logic issue_ready_u0,
    input  ppc_types::exec_op_t op_u0,
    input  logic [0:wb_config::DATA_WIDTH-1] operand_a_u0,
    input  logic [0:wb_config::DATA_WIDTH-1] operand_b_u0,
    input  logic rc_u0,
    input  logic oe_u0,
    input  logic [0:wb_config::RS_ID_WIDTH-1] rs_id_u0,
    input  logic [0:wb_config::GPR_ADDR_WIDTH-1] dest_addr_u0,
    // Unit 1 issue
    input  logic issue_valid_u1,
    output logic issue_ready_u1,
    input  ppc_types::exec_op_t op_u1,
    input  logic [0:wb_config::DATA_WIDTH-1] operand_a_u1,
    input  logic [0:wb_config::DATA_WIDTH-1] operand_b_u1,
    input  logic rc_u1,
    input  logic oe_u1,
    input  logic [0:wb_config::RS_ID_WIDTH-1] rs_id_u1,
    input  logic [0:wb_config::GPR_ADDR_WIDTH-1] dest_addr_u1,
    // Unit 2 issue
    input  logic issue_valid_u2,
    output logic issue_ready_u2,
    input  ppc_types::exec_op_t op_u2,
    input  logic [0:wb_config::DATA_WIDTH-1] operand_a_u2,
    input  logic [0:wb_config::DATA_WIDTH-1] operand_b_u2,
    input  logic rc_u2,
    input  logic oe_u2,
    input  logic [0:wb_config::RS_ID_WIDTH-1] rs_id_u2,
    input  logic [0:wb_config::GPR_ADDR_WIDTH-1] dest_addr_u2,
    // Completion and architectural state
    output logic completion_valid,
    input  logic completion_ready,
    output logic [0:wb_config::RS_ID_WIDTH-1] completion_rs_id,
    input  logic [0:wb_config::GPR_ADDR_WIDTH-1] read_addr,
    output logic [0:wb_config::DATA_WIDTH-1] read_data,
    output logic [0:3] cr0,
    output logic [0:2] xer
);
    import ppc_types::*;
    import wb_config::*;

    // Unit result ports gathered for the arbiter
    logic unit_valid [0:NUM_UNITS-1];
    logic unit_ready [0:NUM_UNITS-1];
    logic [0:RS_ID_WIDTH-1] unit_rs_id [0:NUM_UNITS-1];
    logic [0:GPR_ADDR_WIDTH-1] unit_addr [0:NUM_UNITS-1];
    logic [0:DATA_WIDTH-1] unit_result [0:NUM_UNITS-1];
    cond_exception_t unit_cond [0:NUM_UNITS-1];

    // Shared write-back bus
    logic wb_valid;
    logic wb_ready;
    logic [0:RS_ID_WIDTH-1] wb_rs_id;
    logic [0:GPR_ADDR_WIDTH-1] wb_addr;
    logic [0:DATA_WIDTH-1] wb_result;
    cond_exception_t wb_cond;

    int_exec_unit u_unit0 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid_u0), .issue_ready(issue_ready_u0), .op(op_u0),
        .operand_a(operand_a_u0), .operand_b(operand_b_u0), .rc(rc_u0), .oe(oe_u0),
        .rs_id_in(rs_id_u0), .dest_addr_in(dest_addr_u0),
        .result_valid(unit_valid[0]), .result_ready(unit_ready[0]),
        .rs_id_out(unit_rs_id[0]), .dest_addr_out(unit_addr[0]),
        .result_out(unit_result[0]), .cond_out(unit_cond[0])
    );

    int_exec_unit u_unit1 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid_u1), .issue_ready(issue_ready_u1), .op(op_u1),
        .operand_a(operand_a_u1), .operand_b(operand_b_u1), .rc(rc_u1), .oe(oe_u1),
        .rs_id_in(rs_id_u1), .dest_addr_in(dest_addr_u1),
        .result_valid(unit_valid[1]), .result_ready(unit_ready[1]),
        .rs_id_out(unit_rs_id[1]), .dest_addr_out(unit_addr[1]),
        .result_out(unit_result[1]), .cond_out(unit_cond[1])
    );

    int_exec_unit u_unit2 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid_u2), .issue_ready(issue_ready_u2), .op(op_u2),
        .operand_a(operand_a_u2), .operand_b(operand_b_u2), .rc(rc_u2), .oe(oe_u2),
        .rs_id_in(rs_id_u2), .dest_addr_in(dest_addr_u2),
        .result_valid(unit_valid[2]), .result_ready(unit_ready[2]),
        .rs_id_out(unit_rs_id[2]), .dest_addr_out(unit_addr[2]),
        .result_out(unit_result[2]), .cond_out(unit_cond[2])
    );

    gpr_write_back_arbiter #(
        .ARBITER_DEPTH(NUM_UNITS)
    ) u_arbiter (
        .clk(clk), .rst(rst),
        .input_valid(unit_valid), .input_ready(unit_ready),
        .rs_id_in(unit_rs_id), .result_reg_addr_in(unit_addr),
        .result_in(unit_result), .cr0_xer_in(unit_cond),
        .output_valid(wb_valid), .output_ready(wb_ready),
        .rs_id_out(wb_rs_id), .result_reg_addr_out(wb_addr),
        .result_out(wb_result), .cr0_xer_out(wb_cond)
    );

    gpr_commit u_commit (
        .clk(clk), .rst(rst),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_rs_id(wb_rs_id),
        .wb_addr(wb_addr), .wb_result(wb_result), .wb_cond(wb_cond),
        .completion_valid(completion_valid), .completion_ready(completion_ready),
        .completion_rs_id(completion_rs_id),
        .read_addr(read_addr), .read_data(read_data), .cr0(cr0), .xer(xer)
    );

endmodule

// File: hdl/wb_config.sv
// ##########################################################################
// Write-back sizing
// ##########################################################################

package wb_config;

    // Execution units sharing the write-back bus
    localparam int NUM_UNITS = 3;

    // Reservation-station tag
    localparam int RS_ID_WIDTH = 5;

    // Register file geometry
    localparam int GPR_ADDR_WIDTH = 5;
    localparam int NUM_GPRS = 32;
    localparam int DATA_WIDTH = 32;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the write-back path simulation with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ppc_wb_tb -o ppc_wb_sim -f compile.f \
    && ./obj_dir/ppc_wb_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "Verification passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: sim/ppc_wb_props.sv
// ##########################################################################
// Write-back handshake properties
// ##########################################################################

`timescale 1ns/1ps

module ppc_wb_props (
    input logic clk,
    input logic rst,
    input logic completion_valid,
    input logic completion_ready,
    input logic [0:wb_config::RS_ID_WIDTH-1] completion_rs_id,
    input logic result_valid_u0,
    input logic issue_ready_u0,
    input logic result_valid_u1,
    input logic issue_ready_u1,
    input logic result_valid_u2,
    input logic issue_ready_u2
);

    // No completion straight out of reset
    a_idle_after_rst: assert property (@(posedge clk) rst |=> !completion_valid)
        else $error("completion_valid high in the cycle after reset");

    // Held completion keeps valid and its tag
    a_completion_hold: assert property (@(posedge clk) disable iff (rst)
        completion_valid && !completion_ready |=> completion_valid && $stable(completion_rs_id))
        else $error("completion dropped or changed under back-pressure");

    // A full completion slot stalls every waiting result back to its unit
    a_stall_u0: assert property (@(posedge clk) disable iff (rst)
        completion_valid && !completion_ready && result_valid_u0 |-> !issue_ready_u0)
        else $error("unit 0 ready for issue while its result is stalled");
    a_stall_u1: assert property (@(posedge clk) disable iff (rst)
        completion_valid && !completion_ready && result_valid_u1 |-> !issue_ready_u1)
        else $error("unit 1 ready for issue while its result is stalled");
    a_stall_u2: assert property (@(posedge clk) disable iff (rst)
        completion_valid && !completion_ready && result_valid_u2 |-> !issue_ready_u2)
        else $error("unit 2 ready for issue while its result is stalled");

endmodule

bind ppc_wb_top ppc_wb_props u_props (
    .clk(clk), .rst(rst),
    .completion_valid(completion_valid), .completion_ready(completion_ready),
    .completion_rs_id(completion_rs_id),
    .result_valid_u0(unit_valid[0]), .issue_ready_u0(issue_ready_u0),
    .result_valid_u1(unit_valid[1]), .issue_ready_u1(issue_ready_u1),
    .result_valid_u2(unit_valid[2]), .issue_ready_u2(issue_ready_u2)
);

// File: sim/ppc_wb_tb.sv
// ##########################################################################
// Write-back path testbench
// ##########################################################################

`timescale 1ns/1ps

module ppc_wb_tb;
    import ppc_types::*;

    localparam int ROUNDS_RR = 5;
    localparam int ROUNDS_BP = 8;
    localparam int TOTAL_ISSUES = 3 + 4 * ROUNDS_RR + 3 * ROUNDS_BP + 6 + 7;
    localparam int CYCLE_LIMIT = 40 * TOTAL_ISSUES + 200;

    logic clk;
    logic rst;
    logic issue_valid [0:2];
    logic issue_ready [0:2];
    exec_op_t op [0:2];
    logic [31:0] operand_a [0:2];
    logic [31:0] operand_b [0:2];
    logic rc [0:2];
    logic oe [0:2];
    logic [4:0] rs_id [0:2];
    logic [4:0] dest [0:2];
    logic completion_valid;
    logic completion_ready;
    logic [4:0] completion_rs_id;
    logic [4:0] read_addr;
    logic [31:0] read_data;
    logic [3:0] cr0;
    logic [2:0] xer;

    // Reference model, cr0 is {lt, gt, eq, so} and xer is {so, ov, ca}
    logic [31:0] m_gpr [0:31];
    logic [3:0] m_cr0 = '0;
    logic [2:0] m_xer = '0;
    int m_ptr = 0;
    // Per tag expectations, flags are {ov, ca, rc, oe, ca_en}
    logic [31:0] e_res [0:31];
    logic [4:0] e_dest [0:31];
    logic [4:0] e_flags [0:31];
    int e_unit [0:31];
    logic outstanding [0:31];
    int outstanding_count = 0;
    int expected_order [$];

    logic [31:0] lfsr_state = 32'h53f2;
    logic [4:0] next_tag = '0;
    logic bp_on = 1'b0;
    int bp_left = 0;
    int checks = 0;
    int errors = 0;
    int mark = 0;
    int cycle_count;

    ppc_wb_top UUT (
        .clk(clk), .rst(rst),
        .issue_valid_u0(issue_valid[0]), .issue_ready_u0(issue_ready[0]), .op_u0(op[0]),
        .operand_a_u0(operand_a[0]), .operand_b_u0(operand_b[0]), .rc_u0(rc[0]), .oe_u0(oe[0]),
        .rs_id_u0(rs_id[0]), .dest_addr_u0(dest[0]),
        .issue_valid_u1(issue_valid[1]), .issue_ready_u1(issue_ready[1]), .op_u1(op[1]),
        .operand_a_u1(operand_a[1]), .operand_b_u1(operand_b[1]), .rc_u1(rc[1]), .oe_u1(oe[1]),
        .rs_id_u1(rs_id[1]), .dest_addr_u1(dest[1]),
        .issue_valid_u2(issue_valid[2]), .issue_ready_u2(issue_ready[2]), .op_u2(op[2]),
        .operand_a_u2(operand_a[2]), .operand_b_u2(operand_b[2]), .rc_u2(rc[2]), .oe_u2(oe[2]),
        .rs_id_u2(rs_id[2]), .dest_addr_u2(dest[2]),
        .completion_valid(completion_valid), .completion_ready(completion_ready),
        .completion_rs_id(completion_rs_id), .read_addr(read_addr), .read_data(read_data),
        .cr0(cr0), .xer(xer)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic bit_out;
        bit_out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (bit_out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return bit_out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, sig, exp, got);
        end
    endtask

    // One falling edge, back-pressure stretches drawn here
    task automatic next_cycle();
        @(negedge clk);
        if (bp_on) begin
            if (bp_left == 0) begin
                completion_ready = lfsr_bit();
                bp_left = rand_bits(3) + 1;
            end else begin
                bp_left--;
            end
        end
    endtask

    // Expected result and XER bits from the architected definition
    task automatic record_expect(input int u);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        longint sa;
        longint sb;
        longint wide;
        longint sres;
        logic ov;
        logic ca;
        int tag;
        a = operand_a[u];
        b = operand_b[u];
        sa = $signed(a);
        sb = $signed(b);
        ov = 1'b0;
        ca = 1'b0;
        case (op[u])
            op_and: res = a & b;
            op_or: res = a | b;
            op_xor: res = a ^ b;
            op_subf: begin
                // b minus a, carry means no borrow
                res = b - a;
                wide = sb - sa;
                ca = (b >= a);
            end
            default: begin
                res = a + b;
                wide = sa + sb;
                ca = (res < a);
            end
        endcase
        // Signed overflow when the true sum does not fit in 32 bits
        if (op[u] == op_add || op[u] == op_addc || op[u] == op_subf) begin
            sres = $signed(res);
            ov = (wide != sres);
        end
        tag = rs_id[u];
        e_res[tag] = res;
        e_dest[tag] = dest[u];
        e_flags[tag] = {ov, ca, rc[u], oe[u], (op[u] == op_addc) || (op[u] == op_subf)};
        e_unit[tag] = u;
        outstanding[tag] = 1'b1;
        outstanding_count++;
    endtask

    task automatic load_unit(input int u, input exec_op_t op_in, input logic [31:0] a_in,
                             input logic [31:0] b_in, input logic rc_in, input logic oe_in);
        op[u] = op_in;
        operand_a[u] = a_in;
        operand_b[u] = b_in;
        rc[u] = rc_in;
        oe[u] = oe_in;
        rs_id[u] = next_tag;
        next_tag = next_tag + 1'b1;
        dest[u] = rand_bits(5);
        record_expect(u);
    endtask

    task automatic load_random(input int u, input logic force_rc);
        exec_op_t op_r;
        logic [31:0] a_r;
        logic [31:0] b_r;
        logic rc_r;
        logic oe_r;
        op_r = exec_op_t'(rand_bits(3) % 6);
        a_r = rand_bits(32);
        b_r = rand_bits(32);
        rc_r = force_rc | lfsr_bit();
        oe_r = lfsr_bit();
        load_unit(u, op_r, a_r, b_r, rc_r, oe_r);
    endtask

    // Raise valid on the masked units and hold each until its transfer
    task automatic issue_units(input logic [2:0] mask);
        logic [2:0] pending;
        logic [2:0] taken;
        pending = mask;
        next_cycle();
        for (int u = 0; u < 3; u++) begin
            issue_valid[u] = mask[u];
        end
        while (pending != 3'b000) begin
            #1;
            taken = '0;
            for (int u = 0; u < 3; u++) begin
                taken[u] = pending[u] && issue_ready[u];
            end
            pending = pending & ~taken;
            next_cycle();
            for (int u = 0; u < 3; u++) begin
                if (taken[u]) begin
                    issue_valid[u] = 1'b0;
                end
            end
        end
    endtask

    task automatic wait_idle();
        while (outstanding_count != 0) begin
            next_cycle();
        end
    endtask

    task automatic issue_one(input int u, input exec_op_t op_in, input logic [31:0] a_in,
                             input logic [31:0] b_in, input logic rc_in, input logic oe_in);
        load_unit(u, op_in, a_in, b_in, rc_in, oe_in);
        issue_units(3'b001 << u);
        wait_idle();
    endtask

    // Commit rules applied in completion order
    task automatic commit_model(input int tag);
        logic [31:0] res;
        res = e_res[tag];
        m_gpr[e_dest[tag]] = res;
        if (e_flags[tag][1]) begin
            m_xer[1] = e_flags[tag][4];
            m_xer[2] = m_xer[2] | e_flags[tag][4];
        end
        if (e_flags[tag][0]) begin
            m_xer[0] = e_flags[tag][3];
        end
        // CR0 SO follows XER SO after this update
        if (e_flags[tag][2]) begin
            m_cr0 = {$signed(res) < 0, $signed(res) > 0, res == 0, m_xer[2]};
        end
        m_ptr = (e_unit[tag] + 1) % 3;
    endtask

    task automatic check_state();
        for (int i = 0; i < 32; i++) begin
            next_cycle();
            read_addr = 5'(i);
            #1;
            check_value($sformatf("read_data r%0d", i), m_gpr[i], read_data);
        end
        check_value("cr0", m_cr0, cr0);
        check_value("xer", m_xer, xer);
    endtask

    task automatic close_test(input string name);
        check_state();
        $display("test %s done with %0d errors", name, errors - mark);
        mark = errors;
    endtask

    // Completions are taken on the next rising edge when ready is high here
    initial begin : completion_monitor
        int tag;
        forever begin
            @(negedge clk);
            #1;
            if (!rst && completion_valid && completion_ready) begin
                tag = completion_rs_id;
                checks++;
                assert (outstanding[tag]) else begin
                    errors++;
                    $display("error at %0t ns: tag %0d completed but was not in flight",
                             $time, tag);
                end
                if (outstanding[tag]) begin
                    outstanding[tag] = 1'b0;
                    outstanding_count--;
                    if (expected_order.size() > 0) begin
                        check_value("completion_rs_id order", expected_order.pop_front(), tag);
                    end
                    commit_model(tag);
                    // State already holds this commit and nothing later
                    check_value("cr0", m_cr0, cr0);
                    check_value("xer", m_xer, xer);
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        int u;
        rst = 1'b1;
        completion_ready = 1'b1;
        read_addr = '0;
        for (int i = 0; i < 3; i++) begin
            issue_valid[i] = 1'b0;
            op[i] = op_add;
            operand_a[i] = '0;
            operand_b[i] = '0;
            rc[i] = 1'b0;
            oe[i] = 1'b0;
            rs_id[i] = '0;
            dest[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            m_gpr[i] = '0;
            outstanding[i] = 1'b0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 3; i++) begin
            load_random(i, 1'b0);
            issue_units(3'b001 << i);
            wait_idle();
        end
        close_test("single issue");

        // A lone issue moves the pointer, then all three race
        for (int r = 0; r < ROUNDS_RR; r++) begin
            u = rand_bits(2) % 3;
            load_random(u, 1'b0);
            issue_units(3'b001 << u);
            wait_idle();
            for (int i = 0; i < 3; i++) begin
                load_random(i, 1'b0);
            end
            for (int k = 0; k < 3; k++) begin
                expected_order.push_back(rs_id[(m_ptr + k) % 3]);
            end
            issue_units(3'b111);
            wait_idle();
        end
        close_test("round robin");

        bp_on = 1'b1;
        for (int r = 0; r < ROUNDS_BP; r++) begin
            for (int i = 0; i < 3; i++) begin
                load_random(i, 1'b0);
            end
            issue_units(3'b111);
        end
        wait_idle();
        bp_on = 1'b0;
        completion_ready = 1'b1;
        close_test("back-pressure");

        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 3; i++) begin
                load_random(i, 1'b1);
            end
            issue_units(3'b111);
        end
        wait_idle();
        close_test("record forms");

        issue_one(0, op_addc, 32'hffffffff, 32'h00000001, 1'b0, 1'b0);
        issue_one(1, op_subf, 32'h00000005, 32'h00000003, 1'b1, 1'b0);
        issue_one(2, op_add, 32'h7fffffff, 32'h00000001, 1'b0, 1'b1);
        issue_one(0, op_add, 32'h00000001, 32'h00000002, 1'b0, 1'b0);
        issue_one(1, op_and, 32'hf0f0f0f0, 32'hff00ff00, 1'b0, 1'b0);
        issue_one(2, op_add, 32'h00000001, 32'h00000001, 1'b1, 1'b1);
        // SO sticky after an overflow, even once OV clears
        check_value("xer so", 32'd1, {31'd0, xer[2]});
        issue_one(0, op_subf, 32'h00000001, 32'h80000000, 1'b1, 1'b1);
        close_test("xer");

        $display("%0d checks, %0d passed, %0d errors", checks, checks - errors, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
